//--- dns_filter_top.f
+incdir+common
common/eth_filter_pkg.sv
common/axis_beat_if.sv
parser/dns_reflect_parser.sv
source/frame_delay_line.sv
source/egress_fifo.sv
source/dns_filter_top.sv
test/dns_filter_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dns filter testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f dns_filter_top.f --top-module dns_filter_tb -o dns_filter_sim
sim_out=$(./obj_dir/dns_filter_sim)
echo "$sim_out"
if echo "$sim_out" | grep -qx "test passed"; then
	exit 0
fi
exit 1

//--- test/dns_filter_tb.sv
`timescale 1ns/1ns
`include "eth_filter_cfg.svh"

module dns_filter_tb;
	import eth_filter_pkg::*;

	localparam int NUM_TESTS       = 6;
	localparam int FRAMES_PER_TEST = 12;
	localparam int MAX_LEN         = 16;
	localparam int GAP_CYCLES      = 20;
	localparam int DRAIN_LIMIT     = 200;
	localparam int LAST            = `ETH_DELAY_DEPTH - 1;
	// worst case frame is one bubble per beat
	localparam int STIM_CYCLES = 4 + GAP_CYCLES + NUM_TESTS *
		(FRAMES_PER_TEST * (2 * MAX_LEN + GAP_CYCLES) + DRAIN_LIMIT);
	localparam int WATCHDOG_CYCLES = STIM_CYCLES * 4 + 1000;
	// frame kinds and reply kinds
	localparam int KIND_PLAIN    = 0;
	localparam int KIND_SUSPECT  = 1;
	localparam int KIND_FILTER   = 2;
	localparam int KIND_RANDOM   = 3;
	localparam int REPLY_NONE    = 0;
	localparam int REPLY_ARREST  = 1;
	localparam int REPLY_IGNORED = 2;
	localparam int REPLY_RANDOM  = 3;

	typedef struct packed {
		beat_data_t data;
		beat_keep_t keep;
		logic       last;
	} exp_beat_t;

	logic         clk156;
	logic         eth_rst;
	logic         rx_tvalid;
	beat_data_t   rx_tdata;
	beat_keep_t   rx_tkeep;
	logic         rx_tlast;
	logic         tx_tready;
	logic         tx_tvalid;
	beat_data_t   tx_tdata;
	beat_keep_t   tx_tkeep;
	logic         tx_tlast;
	logic         tx_tuser;
	lookup_key_t  in_key;
	lookup_flag_t in_flag;
	logic         in_valid;
	logic         out_valid;
	lookup_flag_t out_flag;

	// frame under construction
	beat_data_t   frm_data [MAX_LEN];
	beat_keep_t   frm_keep [MAX_LEN];
	int           frm_len;
	lookup_key_t  exp_key;
	lookup_flag_t exp_flag;
	int           exp_reqs;
	// reference delay line and expected transmit order
	logic [LAST:0] mline_valid;
	logic [LAST:0] mline_last;
	beat_data_t    mline_data [`ETH_DELAY_DEPTH];
	beat_keep_t    mline_keep [`ETH_DELAY_DEPTH];
	logic          model_verdict;
	logic          model_first;
	logic          mon_arrest;
	logic          mon_drop;
	exp_beat_t     mon_beat;
	exp_beat_t     exp_q [$];
	// counters of the monitor and of the stimulus
	int req_count   = 0;
	int mon_errs    = 0;
	int checks_done = 0;
	int stim_errs   = 0;
	int tests_run   = 0;
	logic bp_heavy  = 1'b0;
	int ready_low_run = 0;

	dns_filter_top i_dns_filter_top (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.rx_tvalid (rx_tvalid),
		.rx_tdata  (rx_tdata),
		.rx_tkeep  (rx_tkeep),
		.rx_tlast  (rx_tlast),
		.tx_tready (tx_tready),
		.tx_tvalid (tx_tvalid),
		.tx_tdata  (tx_tdata),
		.tx_tkeep  (tx_tkeep),
		.tx_tlast  (tx_tlast),
		.tx_tuser  (tx_tuser),
		.in_key    (in_key),
		.in_flag   (in_flag),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.out_flag  (out_flag)
	);

	initial clk156 = 1'b0;
	always #4 clk156 = ~clk156;

	// big-endian field with the high byte at the lower byte index
	function automatic beat_data_t put16(input beat_data_t b, input int idx, input logic [15:0] v);
		b[8*idx +: 8]     = v[15:8];
		b[8*(idx+1) +: 8] = v[7:0];
		return b;
	endfunction

	// value as it sits in the union fields
	function automatic logic [15:0] to_wire16(input logic [15:0] v);
		return {v[7:0], v[15:8]};
	endfunction

	function automatic lookup_flag_t reply_flag(input int kind);
		logic [1:0] st;
		logic [1:0] r;
		r = 2'($urandom);
		if (kind == REPLY_ARREST) begin
			st = `STATUS_ARREST;
		end else begin
			st = 2'($urandom % 3);
			// any status but arrest
			if (st == `STATUS_ARREST)
				st = 2'b11;
		end
		return {r[1], st, r[0]};
	endfunction

	task automatic check_beat(input beat_data_t got_data, exp_data,
		input beat_keep_t got_keep, exp_keep, input logic got_last, exp_last);
		checks_done++;
		if (got_data !== exp_data || got_keep !== exp_keep || got_last !== exp_last) begin
			$display("mismatch at %0t: tx beat %h keep %h last %b, expected %h keep %h last %b",
				$time, got_data, got_keep, got_last, exp_data, exp_keep, exp_last);
			mon_errs++;
		end
	endtask

	task automatic check_request(input lookup_key_t got_key, exp_k,
		input lookup_flag_t got_flag, exp_f);
		checks_done++;
		if (got_key !== exp_k || got_flag !== exp_f) begin
			$display("mismatch at %0t: lookup key %h flag %b, expected key %h flag %b",
				$time, got_key, got_flag, exp_k, exp_f);
			mon_errs++;
		end
	endtask

	// monitor of requests, transmit beats and the reference line
	always @(posedge clk156) begin
		if (eth_rst) begin
			mline_valid   = '0;
			mline_last    = '0;
			model_verdict = 1'b0;
			model_first   = 1'b1;
		end else begin
			if (in_valid) begin
				req_count++;
				check_request(in_key, exp_key, in_flag, exp_flag);
			end
			if (tx_tuser !== 1'b0) begin
				$display("mismatch at %0t: tx_tuser %b, expected 0", $time, tx_tuser);
				mon_errs++;
			end
			if (tx_tvalid && tx_tready) begin
				if (exp_q.size() == 0) begin
					$display("transmit beat at %0t when no beat was expected", $time);
					mon_errs++;
				end else begin
					mon_beat = exp_q.pop_front();
					check_beat(tx_tdata, mon_beat.data, tx_tkeep, mon_beat.keep,
						tx_tlast, mon_beat.last);
				end
			end
			// arrest reply wipes stages 1 to 7 in the same cycle
			mon_arrest = out_valid && out_flag[2:1] == `STATUS_ARREST;
			mon_drop   = model_verdict || mon_arrest;
			// last stage goes into the fifo
			if (mline_valid[LAST])
				exp_q.push_back({mline_data[LAST], mline_keep[LAST], mline_last[LAST]});
			for (int i = LAST; i > 0; i--) begin
				mline_valid[i] = mon_drop ? 1'b0 : mline_valid[i-1];
				mline_data[i]  = mline_data[i-1];
				mline_keep[i]  = mline_keep[i-1];
				mline_last[i]  = mline_last[i-1];
			end
			mline_valid[0] = rx_tvalid;
			mline_data[0]  = rx_tdata;
			mline_keep[0]  = rx_tkeep;
			mline_last[0]  = rx_tlast;
			// verdict lives until the next first beat
			if (rx_tvalid && model_first)
				model_verdict = 1'b0;
			else if (mon_arrest)
				model_verdict = 1'b1;
			if (rx_tvalid)
				model_first = rx_tlast;
		end
	end

	// one clock of stimulus with tx_tready never low over 4 cycles
	task automatic drive_cycle(input logic v, input beat_data_t d, input beat_keep_t k,
		input logic l, input logic ov, input lookup_flag_t of);
		@(posedge clk156);
		rx_tvalid <= v;
		rx_tdata  <= d;
		rx_tkeep  <= k;
		rx_tlast  <= l;
		out_valid <= ov;
		out_flag  <= of;
		if (ready_low_run >= 4 || $urandom % (bp_heavy ? 2 : 4) != 0) begin
			tx_tready <= 1'b1;
			ready_low_run = 0;
		end else begin
			tx_tready <= 1'b0;
			ready_low_run++;
		end
	endtask

	task automatic drive_idle;
		drive_cycle(1'b0, {$urandom, $urandom}, '0, 1'b0, 1'b0, '0);
	endtask

	// random frame with the headers of its kind and its expected request
	task automatic build_frame(input int kind);
		logic [31:0] sip;
		logic [31:0] dip;
		logic [15:0] sport;
		logic [15:0] dport;
		logic [15:0] parm;
		l4_beat_u    l4;
		frm_len = 12 + int'($urandom % 5);
		for (int i = 0; i < MAX_LEN; i++) begin
			frm_data[i] = {$urandom, $urandom};
			frm_keep[i] = '1;
		end
		frm_keep[frm_len-1] = 8'hff >> ($urandom % 8);
		sip   = $urandom;
		dip   = $urandom;
		dport = 16'($urandom);
		parm  = 16'($urandom);
		frm_data[1] = put16(frm_data[1], 4, `ETH_FTYPE_IP);
		frm_data[2][63:56] = (kind == KIND_FILTER) ? `IP_PROTO_ICMP : `IP_PROTO_UDP;
		frm_data[3] = put16(frm_data[3], 2, sip[31:16]);
		frm_data[3] = put16(frm_data[3], 4, sip[15:0]);
		frm_data[3] = put16(frm_data[3], 6, dip[31:16]);
		l4 = frm_data[4];
		l4.udp.dst_ip_lo_sw = to_wire16(dip[15:0]);
		if (kind == KIND_FILTER) begin
			l4.icmp.icmp_type = `ICMP_DEST_UNREACH;
			l4.icmp.icmp_code = `ICMP_PORT_UNREACH;
		end else begin
			sport = (kind == KIND_SUSPECT) ? `DNS_SERV_PORT : 16'($urandom);
			// plain udp never from the server port
			if (kind == KIND_PLAIN && sport == `DNS_SERV_PORT)
				sport = sport ^ 16'd1;
			l4.udp.src_port_sw = to_wire16(sport);
			l4.udp.dst_port_sw = to_wire16(dport);
		end
		frm_data[4] = l4;
		exp_key  = '0;
		exp_flag = '0;
		exp_reqs = 0;
		if (kind == KIND_SUSPECT) begin
			frm_data[5] = put16(frm_data[5], 4, parm);
			exp_key  = {sip, dip, dport, 16'd0};
			exp_flag = parm[0] ? `OP_SUSPECT : '0;
			exp_reqs = 1;
		end else if (kind == KIND_FILTER) begin
			// quoted header gets fresh addresses and reuses the port
			sip   = $urandom;
			dip   = $urandom;
			frm_data[6] = put16(frm_data[6], 6, sip[31:16]);
			frm_data[7] = put16(frm_data[7], 0, sip[15:0]);
			frm_data[7] = put16(frm_data[7], 2, dip[31:16]);
			frm_data[7] = put16(frm_data[7], 4, dip[15:0]);
			frm_data[8] = put16(frm_data[8], 0, dport);
			frm_data[9] = put16(frm_data[9], 0, parm);
			exp_key  = {sip, dip, dport, 16'd0};
			exp_flag = parm[0] ? `OP_ARREST : '0;
			exp_reqs = 1;
		end
	endtask

	task automatic send_frame(input int reply_sel);
		int   reply_kind;
		int   reply_at;
		logic rv;
		reply_kind = (reply_sel == REPLY_RANDOM) ? int'($urandom % 3) : reply_sel;
		// never on beat 0 since that beat clears the verdict
		reply_at = 1 + int'($urandom % (frm_len - 1));
		for (int b = 0; b < frm_len; b++) begin
			if (b > 0 && $urandom % 4 == 0)
				drive_idle();
			rv = reply_kind != REPLY_NONE && b == reply_at;
			drive_cycle(1'b1, frm_data[b], frm_keep[b], b == frm_len - 1, rv,
				rv ? reply_flag(reply_kind) : '0);
		end
		repeat (GAP_CYCLES) drive_idle();
	endtask

	task automatic wait_drain;
		int n;
		n = 0;
		while ((exp_q.size() != 0 || mline_valid != '0) && n < DRAIN_LIMIT) begin
			drive_idle();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected beats never left the transmit port", exp_q.size());
			stim_errs++;
		end
	endtask

	task automatic run_test(input int num, input string name, input int kind_sel,
		input int reply_sel, input logic heavy);
		int errs_before;
		int reqs_before;
		int kind;
		errs_before = mon_errs + stim_errs;
		bp_heavy = heavy;
		for (int f = 0; f < FRAMES_PER_TEST; f++) begin
			kind = (kind_sel == KIND_RANDOM) ? int'($urandom % 3) : kind_sel;
			build_frame(kind);
			reqs_before = req_count;
			send_frame(reply_sel);
			if (req_count - reqs_before != exp_reqs) begin
				$display("mismatch at %0t: frame %0d of test %0d made %0d lookup requests, expected %0d",
					$time, f, num, req_count - reqs_before, exp_reqs);
				stim_errs++;
			end
		end
		wait_drain();
		tests_run++;
		$display("test %0d %s: %0d frames, %0d errors", num, name, FRAMES_PER_TEST,
			mon_errs + stim_errs - errs_before);
	endtask

	initial begin
		void'($urandom(32'hecab1fcd));
		eth_rst   = 1'b1;
		// a beat offered during reset must not raise in_valid
		rx_tvalid = 1'b1;
		rx_tdata  = '0;
		rx_tkeep  = '0;
		rx_tlast  = 1'b0;
		tx_tready = 1'b0;
		out_valid = 1'b0;
		out_flag  = '0;
		repeat (4) @(posedge clk156);
		eth_rst   <= 1'b0;
		rx_tvalid <= 1'b0;
		if (tx_tvalid !== 1'b0 || in_valid !== 1'b0) begin
			$display("mismatch at %0t: tx_tvalid %b in_valid %b after reset, expected 0",
				$time, tx_tvalid, in_valid);
			stim_errs++;
		end
		run_test(1, "plain pass-through", KIND_PLAIN, REPLY_NONE, 1'b0);
		run_test(2, "suspect request", KIND_SUSPECT, REPLY_NONE, 1'b0);
		run_test(3, "filter request", KIND_FILTER, REPLY_NONE, 1'b0);
		run_test(4, "arrest reply", KIND_RANDOM, REPLY_ARREST, 1'b0);
		run_test(5, "ignored reply", KIND_RANDOM, REPLY_IGNORED, 1'b0);
		run_test(6, "back-pressure", KIND_RANDOM, REPLY_RANDOM, 1'b1);
		// stray beats would still show up here
		repeat (GAP_CYCLES) drive_idle();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks_done,
			mon_errs + stim_errs);
		if (mon_errs + stim_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk156);
		$display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

//--- source/dns_filter_top.sv
`timescale 1ns/1ns
`include "eth_filter_cfg.svh"

module dns_filter_top (
	input  logic                         clk156,
	input  logic                         eth_rst,
	// receive lane
	input  logic                         rx_tvalid,
	input  eth_filter_pkg::beat_data_t   rx_tdata,
	input  eth_filter_pkg::beat_keep_t   rx_tkeep,
	input  logic                         rx_tlast,
	// transmit lane
	input  logic                         tx_tready,
	output logic                         tx_tvalid,
	output eth_filter_pkg::beat_data_t   tx_tdata,
	output eth_filter_pkg::beat_keep_t   tx_tkeep,
	output logic                         tx_tlast,
	output logic                         tx_tuser,
	// flow table request
	output eth_filter_pkg::lookup_key_t  in_key,
	output eth_filter_pkg::lookup_flag_t in_flag,
	output logic                         in_valid,
	// flow table reply
	input  logic                         out_valid,
	input  eth_filter_pkg::lookup_flag_t out_flag
);

	// parser verdict into the delay line
	logic frame_drop;

	axis_beat_if beat_link ();

	// header parse and lookup request
	dns_reflect_parser i_dns_reflect_parser (
		.clk156     (clk156),
		.eth_rst    (eth_rst),
		.rx_tvalid  (rx_tvalid),
		.rx_tdata   (rx_tdata),
		.rx_tlast   (rx_tlast),
		.out_valid  (out_valid),
		.out_flag   (out_flag),
		.in_key     (in_key),
		.in_flag    (in_flag),
		.in_valid   (in_valid),
		.frame_drop (frame_drop)
	);

	// holds beats while the lookup is in flight
	frame_delay_line i_frame_delay_line (
		.clk156     (clk156),
		.eth_rst    (eth_rst),
		.rx_tvalid  (rx_tvalid),
		.rx_tdata   (rx_tdata),
		.rx_tkeep   (rx_tkeep),
		.rx_tlast   (rx_tlast),
		.frame_drop (frame_drop),
		.beat_out   (beat_link.source)
	);

	egress_fifo #(
		.DEPTH (`ETH_FIFO_DEPTH)
	) i_egress_fifo (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.beat_in   (beat_link.sink),
		.tx_tready (tx_tready),
		.tx_tvalid (tx_tvalid),
		.tx_tdata  (tx_tdata),
		.tx_tkeep  (tx_tkeep),
		.tx_tlast  (tx_tlast)
	);

	// no user sideband on transmit
	assign tx_tuser = 1'b0;

endmodule

//--- source/egress_fifo.sv
`timescale 1ns/1ns
`include "eth_filter_cfg.svh"

module egress_fifo #(
	parameter int DEPTH = `ETH_FIFO_DEPTH
) (
	input  logic                       clk156,
	input  logic                       eth_rst,
	axis_beat_if.sink                  beat_in,
	input  logic                       tx_tready,
	output logic                       tx_tvalid,
	output eth_filter_pkg::beat_data_t tx_tdata,
	output eth_filter_pkg::beat_keep_t tx_tkeep,
	output logic                       tx_tlast
);
	import eth_filter_pkg::*;

	localparam int ADDR_W = $clog2(DEPTH);

	beat_data_t        mem_data [DEPTH];
	beat_keep_t        mem_keep [DEPTH];
	logic [DEPTH-1:0]  mem_last;
	// extra msb tells full from empty
	logic [ADDR_W:0]   wr_ptr;
	logic [ADDR_W:0]   rd_ptr;
	logic              fifo_empty;
	logic              fifo_full;
	logic              do_write;
	logic              do_read;

	assign fifo_empty = wr_ptr == rd_ptr;
	assign fifo_full  = wr_ptr[ADDR_W] != rd_ptr[ADDR_W] &&
		wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0];
	// input cannot stall, overflow beats are lost
	assign do_write = beat_in.valid && !fifo_full;
	// refill output register when empty or taken
	assign do_read  = !fifo_empty && (!tx_tvalid || tx_tready);

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			tx_tvalid <= 1'b0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_read)
				tx_tvalid <= 1'b1;
			else if (tx_tready)
				tx_tvalid <= 1'b0;
		end
	end

	// storage
	always_ff @(posedge clk156) begin
		if (do_write) begin
			mem_data[wr_ptr[ADDR_W-1:0]] <= beat_in.data;
			mem_keep[wr_ptr[ADDR_W-1:0]] <= beat_in.keep;
			mem_last[wr_ptr[ADDR_W-1:0]] <= beat_in.last;
		end
	end

	// registered head of queue
	always_ff @(posedge clk156) begin
		if (do_read) begin
			tx_tdata <= mem_data[rd_ptr[ADDR_W-1:0]];
			tx_tkeep <= mem_keep[rd_ptr[ADDR_W-1:0]];
			tx_tlast <= mem_last[rd_ptr[ADDR_W-1:0]];
		end
	end

endmodule

//--- source/frame_delay_line.sv
`timescale 1ns/1ns
`include "eth_filter_cfg.svh"

module frame_delay_line (
	input  logic                       clk156,
	input  logic                       eth_rst,
	input  logic                       rx_tvalid,
	input  eth_filter_pkg::beat_data_t rx_tdata,
	input  eth_filter_pkg::beat_keep_t rx_tkeep,
	input  logic                       rx_tlast,
	input  logic                       frame_drop,
	axis_beat_if.source                beat_out
);
	import eth_filter_pkg::*;

	localparam int LAST_STG = `ETH_DELAY_DEPTH - 1;

	logic [LAST_STG:0] stg_valid;
	logic [LAST_STG:0] stg_last;
	beat_data_t        stg_data [`ETH_DELAY_DEPTH];
	beat_keep_t        stg_keep [`ETH_DELAY_DEPTH];

	// free-running shift, no stall
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			stg_valid <= '0;
			stg_last  <= '0;
			for (int i = 0; i <= LAST_STG; i++) begin
				stg_data[i] <= '0;
				stg_keep[i] <= '0;
			end
		end else begin
			// stage 0 always takes the input
			stg_valid[0] <= rx_tvalid;
			stg_data[0]  <= rx_tdata;
			stg_keep[0]  <= rx_tkeep;
			stg_last[0]  <= rx_tlast;
			for (int i = 1; i <= LAST_STG; i++) begin
				// dropped frame leaves as bubbles
				stg_valid[i] <= frame_drop ? 1'b0 : stg_valid[i-1];
				stg_data[i]  <= frame_drop ? '0 : stg_data[i-1];
				stg_keep[i]  <= frame_drop ? '0 : stg_keep[i-1];
				stg_last[i]  <= frame_drop ? 1'b0 : stg_last[i-1];
			end
		end
	end

	assign beat_out.valid = stg_valid[LAST_STG];
	assign beat_out.data  = stg_data[LAST_STG];
	assign beat_out.keep  = stg_keep[LAST_STG];
	assign beat_out.last  = stg_last[LAST_STG];

endmodule

//--- parser/dns_reflect_parser.sv
`timescale 1ns/1ns
`include "eth_filter_cfg.svh"

module dns_reflect_parser (
	input  logic                         clk156,
	input  logic                         eth_rst,
	input  logic                         rx_tvalid,
	input  eth_filter_pkg::beat_data_t   rx_tdata,
	input  logic                         rx_tlast,
	input  logic                         out_valid,
	input  eth_filter_pkg::lookup_flag_t out_flag,
	output eth_filter_pkg::lookup_key_t  in_key,
	output eth_filter_pkg::lookup_flag_t in_flag,
	output logic                         in_valid,
	output logic                         frame_drop
);
	import eth_filter_pkg::*;

	// valid beats seen in this frame
	logic [`ETH_BEAT_CNT_W-1:0] beat_idx;
	// outer fields that steer the mode decode
	logic [15:0]  rx_ftype;
	logic [7:0]   rx_ip_proto;
	logic [15:0]  rx_src_uport;
	logic [7:0]   rx_icmp_type;
	logic [7:0]   rx_icmp_code;
	// outer key and dns parameter word
	logic [31:0]  rx_src_ip;
	logic [31:0]  rx_dst_ip;
	logic [15:0]  rx_dst_uport;
	logic [15:0]  suspect_parm_dns;
	// header quoted inside the icmp payload
	logic [31:0]  filter_src_ip;
	logic [31:0]  filter_dst_ip;
	logic [15:0]  filter_dst_udp;
	logic [15:0]  filter_parm_dns;
	lookup_flag_t db_op;
	logic         verdict;
	l4_beat_u     l4_beat;
	logic         is_ipv4_udp;
	logic         is_ipv4_icmp;
	logic         suspect_mode;
	logic         filter_mode;
	logic         arrest_reply;

	// wire byte order to big-endian value
	function automatic logic [15:0] swap16(input logic [15:0] w);
		return {w[7:0], w[15:8]};
	endfunction

	assign l4_beat = rx_tdata;

	assign is_ipv4_udp  = rx_ftype == `ETH_FTYPE_IP && rx_ip_proto == `IP_PROTO_UDP;
	assign is_ipv4_icmp = rx_ftype == `ETH_FTYPE_IP && rx_ip_proto == `IP_PROTO_ICMP;
	// response from our dns server
	assign suspect_mode = is_ipv4_udp && rx_src_uport == `DNS_SERV_PORT;
	// port unreachable coming back for a reflected response
	assign filter_mode  = is_ipv4_icmp && rx_icmp_type == `ICMP_DEST_UNREACH &&
		rx_icmp_code == `ICMP_PORT_UNREACH;

	assign arrest_reply = out_valid && out_flag[2:1] == `STATUS_ARREST;

	// beat counter, mode fields, opcode, verdict
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			beat_idx     <= '0;
			rx_ftype     <= '0;
			rx_ip_proto  <= '0;
			rx_src_uport <= '0;
			rx_icmp_type <= '0;
			rx_icmp_code <= '0;
			db_op        <= '0;
			verdict      <= 1'b0;
		end else begin
			if (arrest_reply)
				verdict <= 1'b1;
			if (rx_tvalid) begin
				// saturate on oversized frames
				if (rx_tlast)
					beat_idx <= '0;
				else if (beat_idx != '1)
					beat_idx <= beat_idx + 1'b1;
				if (beat_idx == '0) begin
					rx_ftype     <= '0;
					rx_ip_proto  <= '0;
					rx_src_uport <= '0;
					rx_icmp_type <= '0;
					rx_icmp_code <= '0;
					db_op        <= '0;
					// new frame wins over a late reply
					verdict      <= 1'b0;
				end
				if (beat_idx == `BEAT_FTYPE)
					rx_ftype <= swap16(rx_tdata[47:32]);
				if (beat_idx == `BEAT_PROTO)
					rx_ip_proto <= rx_tdata[63:56];
				if (beat_idx == `BEAT_L4_HDR) begin
					if (is_ipv4_udp) begin
						rx_src_uport <= swap16(l4_beat.udp.src_port_sw);
					end else if (is_ipv4_icmp) begin
						rx_icmp_type <= l4_beat.icmp.icmp_type;
						rx_icmp_code <= l4_beat.icmp.icmp_code;
					end
				end
				// only dns responses get flagged
				if (suspect_mode && suspect_parm_dns[0] && beat_idx == `BEAT_SUSPECT_FLAG)
					db_op <= `OP_SUSPECT;
				if (filter_mode && filter_parm_dns[0] && beat_idx == `BEAT_FILTER_FLAG)
					db_op <= `OP_ARREST;
			end
		end
	end

	// key fields and dns parameter words
	always_ff @(posedge clk156) begin
		if (rx_tvalid) begin
			if (beat_idx == '0) begin
				rx_src_ip        <= '0;
				rx_dst_ip        <= '0;
				rx_dst_uport     <= '0;
				suspect_parm_dns <= '0;
				filter_src_ip    <= '0;
				filter_dst_ip    <= '0;
				filter_dst_udp   <= '0;
				filter_parm_dns  <= '0;
			end
			if (beat_idx == `BEAT_IP_ADDR) begin
				rx_src_ip        <= {swap16(rx_tdata[31:16]), swap16(rx_tdata[47:32])};
				rx_dst_ip[31:16] <= swap16(rx_tdata[63:48]);
			end
			if (beat_idx == `BEAT_L4_HDR) begin
				rx_dst_ip[15:0] <= swap16(l4_beat.udp.dst_ip_lo_sw);
				if (is_ipv4_udp)
					rx_dst_uport <= swap16(l4_beat.udp.dst_port_sw);
			end
			// dns flags word after the query id
			if (suspect_mode && beat_idx == `BEAT_DNS_PARAM)
				suspect_parm_dns <= swap16(rx_tdata[47:32]);
			// inner ip addresses straddle beats 6 and 7
			if (filter_mode && beat_idx == `BEAT_INNER_SRC_HI)
				filter_src_ip[31:16] <= swap16(rx_tdata[63:48]);
			if (filter_mode && beat_idx == `BEAT_INNER_ADDR) begin
				filter_src_ip[15:0] <= swap16(rx_tdata[15:0]);
				filter_dst_ip       <= {swap16(rx_tdata[31:16]), swap16(rx_tdata[47:32])};
			end
			if (filter_mode && beat_idx == `BEAT_INNER_PORT)
				filter_dst_udp <= swap16(rx_tdata[15:0]);
			if (filter_mode && beat_idx == `BEAT_INNER_PARAM)
				filter_parm_dns <= swap16(rx_tdata[15:0]);
		end
	end

	// request goes out once all key fields are in
	assign in_valid = rx_tvalid &&
		((suspect_mode && beat_idx == `BEAT_SUSPECT_REQ) ||
		 (filter_mode && beat_idx == `BEAT_FILTER_REQ));
	assign in_flag  = db_op;
	assign in_key   = suspect_mode ? {rx_src_ip, rx_dst_ip, rx_dst_uport, 16'd0} :
		filter_mode ? {filter_src_ip, filter_dst_ip, filter_dst_udp, 16'd0} : '0;

	// wipe the delay line from the reply cycle on
	assign frame_drop = verdict || arrest_reply;

endmodule

//--- common/axis_beat_if.sv
`timescale 1ns/1ns

interface axis_beat_if;
	import eth_filter_pkg::*;

	// delayed receive beat, no ready
	logic       valid;
	beat_data_t data;
	beat_keep_t keep;
	logic       last;

	// delay line side
	modport source (output valid, data, keep, last);
	// fifo side
	modport sink (input valid, data, keep, last);

endinterface

//--- common/eth_filter_pkg.sv
`include "eth_filter_cfg.svh"

package eth_filter_pkg;

	// one receive or transmit beat
	typedef logic [`ETH_DATA_W-1:0] beat_data_t;
	// byte enables of a beat
	typedef logic [`ETH_KEEP_W-1:0] beat_keep_t;

	// src ip, dst ip, dst port, 16 zero bits
	typedef logic [`ETH_KEY_W-1:0] lookup_key_t;
	// lookup opcode, status in bits 2:1
	typedef logic [`ETH_FLAG_W-1:0] lookup_flag_t;

	// beat 4 of an ipv4 frame
	// byte 0 sits in bits 7:0, so 16-bit fields arrive byte-swapped
	typedef union packed {
		// udp header start
		struct packed {
			logic [15:0] rsvd;
			logic [15:0] dst_port_sw;
			logic [15:0] src_port_sw;
			logic [15:0] dst_ip_lo_sw;
		} udp;
		// icmp header start
		struct packed {
			logic [31:0] rsvd;
			logic [7:0]  icmp_code;
			logic [7:0]  icmp_type;
			logic [15:0] dst_ip_lo_sw;
		} icmp;
	} l4_beat_u;

endpackage

//--- common/eth_filter_cfg.svh
`ifndef ETH_FILTER_CFG_SVH
`define ETH_FILTER_CFG_SVH

// datapath widths
`define ETH_DATA_W      64
`define ETH_KEEP_W      8
// flow table lookup
`define ETH_KEY_W       96
`define ETH_FLAG_W      4
// buffering
`define ETH_DELAY_DEPTH 8
`define ETH_FIFO_DEPTH  64
`define ETH_BEAT_CNT_W  10

// protocol constants
`define ETH_FTYPE_IP      16'h0800
`define IP_PROTO_UDP      8'd17
`define IP_PROTO_ICMP     8'd1
`define ICMP_DEST_UNREACH 8'd3
`define ICMP_PORT_UNREACH 8'd3
// debug server port, not the well-known 53
`define DNS_SERV_PORT     16'd12345

// lookup opcodes and reply status
`define OP_SUSPECT    4'b0011
`define OP_ARREST     4'b0101
`define STATUS_ARREST 2'b10

// beat positions of header fields, counted from 0
`define BEAT_FTYPE        1
`define BEAT_PROTO        2
`define BEAT_IP_ADDR      3
`define BEAT_L4_HDR       4
`define BEAT_DNS_PARAM    5
`define BEAT_SUSPECT_FLAG 6
`define BEAT_SUSPECT_REQ  7
`define BEAT_INNER_SRC_HI 6
`define BEAT_INNER_ADDR   7
`define BEAT_INNER_PORT   8
`define BEAT_INNER_PARAM  9
`define BEAT_FILTER_FLAG  10
`define BEAT_FILTER_REQ   11

`endif
